// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tunnel_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --assert --timing
PASS_MSG  ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | awk '{ print } index($$0, "$(PASS_MSG)") { ok = 1 } \
		END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/tunnel_tb.sv ====
/*
 * testbench for the two-endpoint channel tunnel
 * random traffic both ways with scoreboards and credit checks
 */

`timescale 1ns/1ps

module tunnel_tb import tunnel_pkg::*; ();

   localparam int          TIMEOUT    = 400;
   localparam int          RUN_CYCLES = 2000;
   localparam int unsigned SEED       = 32'h6792_b142;

   logic clk = 1'b0;
   logic rst = 1'b1;

   ch_data_t          a_tx_data  = '0;
   logic [NUM_CH-1:0] a_tx_valid = '0;
   logic [NUM_CH-1:0] a_tx_yumi;
   ch_data_t          a_rx_data;
   logic [NUM_CH-1:0] a_rx_valid;
   logic [NUM_CH-1:0] a_rx_yumi  = '0;
   ch_data_t          b_tx_data  = '0;
   logic [NUM_CH-1:0] b_tx_valid = '0;
   logic [NUM_CH-1:0] b_tx_yumi;
   ch_data_t          b_rx_data;
   logic [NUM_CH-1:0] b_rx_valid;
   logic [NUM_CH-1:0] b_rx_yumi  = '0;

   // traffic phases
   logic offer    = 1'b0;
   logic stall0   = 1'b1;
   logic released = 1'b0;
   logic drain    = 1'b0;

   // ab scoreboards run from A tx to B rx and ba the reverse
   logic [DATA_W-1:0] q_ab [NUM_CH][$];
   logic [DATA_W-1:0] q_ba [NUM_CH][$];
   logic [DATA_W-1:0] exp_ab [NUM_CH];
   logic [DATA_W-1:0] exp_ba [NUM_CH];
   logic [NUM_CH-1:0] exp_ab_v = '0;
   logic [NUM_CH-1:0] exp_ba_v = '0;
   logic [NUM_CH-1:0] a_taken  = '0;
   logic [NUM_CH-1:0] b_taken  = '0;
   int acc0        = 0;
   int rel_acc     = 0;
   int rel_drain   = 0;
   int iso_ab      = 0;
   int iso_ba      = 0;
   int outstanding = 0;

   tunnel_link DUT (
      .clk_i        (clk),
      .rst_i        (rst),
      .a_tx_data_i  (a_tx_data),
      .a_tx_valid_i (a_tx_valid),
      .a_tx_yumi_o  (a_tx_yumi),
      .a_rx_data_o  (a_rx_data),
      .a_rx_valid_o (a_rx_valid),
      .a_rx_yumi_i  (a_rx_yumi),
      .b_tx_data_i  (b_tx_data),
      .b_tx_valid_i (b_tx_valid),
      .b_tx_yumi_o  (b_tx_yumi),
      .b_rx_data_o  (b_rx_data),
      .b_rx_valid_o (b_rx_valid),
      .b_rx_yumi_i  (b_rx_yumi)
   );

   always #2 clk = ~clk;

   task automatic report_error(input string msg);
      $display("ERROR %0t: %s", $time, msg);
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic fail_timeout(input string what);
      $display("timeout at %0t: %s", $time, what);
      $display("Test failures found");
      $fatal(1);
   endtask

   // producers hold a word until it is taken and consumers take at random
   always @(negedge clk) begin
      for (int c = 0; c < NUM_CH; c++) begin
         if (!offer) begin
            a_tx_valid[c] <= 1'b0;
            b_tx_valid[c] <= 1'b0;
         end else begin
            if (!a_tx_valid[c] || a_taken[c]) begin
               a_tx_valid[c] <= (stall0 && c == 0) || (($urandom % 4) != 0);
               a_tx_data[c]  <= DATA_W'($urandom);
            end
            if (!b_tx_valid[c] || b_taken[c]) begin
               b_tx_valid[c] <= (($urandom % 4) != 0);
               b_tx_data[c]  <= DATA_W'($urandom);
            end
         end
         a_rx_yumi[c] <= a_rx_valid[c] && (drain || (($urandom % 2) == 0));
         b_rx_yumi[c] <= b_rx_valid[c] && !(stall0 && c == 0) &&
                         (drain || (($urandom % 2) == 0));
      end
   end

   // record accepted words, retire delivered ones, publish the next expected
   always @(posedge clk) begin
      outstanding = 0;
      for (int c = 0; c < NUM_CH; c++) begin
         a_taken[c] = !rst && a_tx_valid[c] && a_tx_yumi[c];
         b_taken[c] = !rst && b_tx_valid[c] && b_tx_yumi[c];
         if (a_taken[c]) q_ab[c].push_back(a_tx_data[c]);
         if (b_taken[c]) q_ba[c].push_back(b_tx_data[c]);
         if (b_rx_valid[c] && b_rx_yumi[c] && q_ab[c].size() > 0) begin
            void'(q_ab[c].pop_front());
            // isolation only counts once A channel 0 is out of credit
            if (stall0 && acc0 == REMOTE_CREDITS && c != 0) iso_ab++;
            if (released && c == 0) rel_drain++;
         end
         if (a_rx_valid[c] && a_rx_yumi[c] && q_ba[c].size() > 0) begin
            void'(q_ba[c].pop_front());
            if (stall0 && acc0 == REMOTE_CREDITS && c != 0) iso_ba++;
         end
         exp_ab_v[c] = q_ab[c].size() > 0;
         exp_ba_v[c] = q_ba[c].size() > 0;
         exp_ab[c]   = exp_ab_v[c] ? q_ab[c][0] : '0;
         exp_ba[c]   = exp_ba_v[c] ? q_ba[c][0] : '0;
         outstanding += q_ab[c].size() + q_ba[c].size();
      end
      if (stall0 && a_taken[0]) acc0++;
      if (released && a_taken[0]) rel_acc++;
   end

   assert property (@(posedge clk) $fell(rst) |-> (a_rx_valid == '0 && b_rx_valid == '0))
      else report_error("rx valid high right after reset");

   assert property (@(posedge clk) ((a_tx_yumi & ~a_tx_valid) == '0))
      else report_error("A tx yumi without tx valid");

   assert property (@(posedge clk) ((b_tx_yumi & ~b_tx_valid) == '0))
      else report_error("B tx yumi without tx valid");

   // held-off consumer on B channel 0 caps A at its initial credit
   assert property (@(posedge clk) disable iff (rst)
      (stall0 && a_tx_valid[0] && a_tx_yumi[0]) |-> (acc0 < REMOTE_CREDITS))
      else report_error("A channel 0 accepted a word beyond its credit");

   for (genvar c = 0; c < NUM_CH; c++) begin : g_order
      assert property (@(posedge clk) disable iff (rst)
         (b_rx_valid[c] && b_rx_yumi[c]) |-> (exp_ab_v[c] && b_rx_data[c] == exp_ab[c]))
         else report_error($sformatf("B channel %0d delivered a wrong word", c));

      assert property (@(posedge clk) disable iff (rst)
         (a_rx_valid[c] && a_rx_yumi[c]) |-> (exp_ba_v[c] && a_rx_data[c] == exp_ba[c]))
         else report_error($sformatf("A channel %0d delivered a wrong word", c));
   end

   initial begin
      int t;
      void'($urandom(SEED));
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst   <= 1'b0;
      offer <= 1'b1;

      // B consumer 0 held off while A keeps offering channel 0
      for (t = 0; t < TIMEOUT && acc0 < REMOTE_CREDITS; t++) @(negedge clk);
      if (acc0 < REMOTE_CREDITS) fail_timeout("A channel 0 never used its initial credits");
      repeat (TIMEOUT) @(negedge clk);
      assert (iso_ab > 0 && iso_ba > 0)
         else report_error("channels 1 and 2 stopped while channel 0 was stalled");

      // released consumer returns credits that must reopen channel 0
      stall0   <= 1'b0;
      released <= 1'b1;
      for (t = 0; t < TIMEOUT && (rel_drain < REMOTE_CREDITS || rel_acc == 0); t++) begin
         @(negedge clk);
      end
      if (rel_drain < REMOTE_CREDITS || rel_acc == 0) begin
         fail_timeout("channel 0 did not resume after the consumer was released");
      end

      repeat (RUN_CYCLES) @(negedge clk);

      // stop producers and let every consumer drain
      offer <= 1'b0;
      drain <= 1'b1;
      repeat (2) @(negedge clk);
      for (t = 0; t < TIMEOUT && outstanding != 0; t++) @(negedge clk);
      if (outstanding != 0) fail_timeout("scoreboard queues did not empty");

      $display("All tests passed!");
      $finish;
   end

endmodule

// ==== sources.f ====
src/tunnel_pkg.sv
src/credit_counter.sv
src/rr_arbiter.sv
src/channel_fifo.sv
src/channel_tunnel_out.sv
src/channel_tunnel_in.sv
src/channel_tunnel.sv
src/tunnel_link.sv
bench/tunnel_tb.sv

// ==== src/channel_fifo.sv ====
/*
 * receive FIFO for one tunneled channel
 * depth equals the credits granted to the remote sender
 */

`timescale 1ns/1ps

module channel_fifo import tunnel_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic [DATA_W-1:0] data_i,
   input  logic              valid_i,
   output logic [DATA_W-1:0] data_o,
   output logic              valid_o,
   input  logic              yumi_i
);

   logic [DATA_W-1:0]     mem [REMOTE_CREDITS];
   logic [FIFO_PTR_W-1:0] wr_ptr_q;
   logic [FIFO_PTR_W-1:0] rd_ptr_q;
   logic [CREDIT_W-1:0]   count_q;

   // the sender never holds more credits than there are entries
   always_ff @(posedge clk_i) begin
      if (valid_i) begin
         mem[wr_ptr_q] <= data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (valid_i) begin
            wr_ptr_q <= (wr_ptr_q == FIFO_PTR_W'(REMOTE_CREDITS - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (yumi_i) begin
            rd_ptr_q <= (rd_ptr_q == FIFO_PTR_W'(REMOTE_CREDITS - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         count_q <= count_q + CREDIT_W'(valid_i) - CREDIT_W'(yumi_i);
      end
   end

   assign valid_o = (count_q != '0);
   assign data_o  = mem[rd_ptr_q];

endmodule

// ==== src/channel_tunnel.sv ====
/*
 * one channel tunnel endpoint
 * outbound and inbound sides joined by their credit paths
 */

`timescale 1ns/1ps

module channel_tunnel import tunnel_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_i,
   // local producers
   input  ch_data_t          tx_data_i,
   input  logic [NUM_CH-1:0] tx_valid_i,
   output logic [NUM_CH-1:0] tx_yumi_o,
   // local consumers
   output ch_data_t          rx_data_o,
   output logic [NUM_CH-1:0] rx_valid_o,
   input  logic [NUM_CH-1:0] rx_yumi_i,
   // link toward the remote endpoint
   output flit_t             link_flit_o,
   output logic              link_valid_o,
   input  logic              link_yumi_i,
   // link from the remote endpoint
   input  flit_t             link_flit_i,
   input  logic              link_valid_i,
   output logic              link_yumi_o
);

   credit_vec_t credit_return;
   logic        credit_return_v;
   credit_vec_t credit_pending;
   logic        credit_sent;

   channel_tunnel_out u_out (
      .clk_i                   (clk_i),
      .rst_i                   (rst_i),
      .ch_data_i               (tx_data_i),
      .ch_valid_i              (tx_valid_i),
      .ch_yumi_o               (tx_yumi_o),
      .link_flit_o             (link_flit_o),
      .link_valid_o            (link_valid_o),
      .link_yumi_i             (link_yumi_i),
      .credit_local_return_i   (credit_return),
      .credit_local_return_v_i (credit_return_v),
      .credit_remote_pending_i (credit_pending),
      .credit_sent_o           (credit_sent)
   );

   channel_tunnel_in u_in (
      .clk_i                   (clk_i),
      .rst_i                   (rst_i),
      .link_flit_i             (link_flit_i),
      .link_valid_i            (link_valid_i),
      .link_yumi_o             (link_yumi_o),
      .ch_data_o               (rx_data_o),
      .ch_valid_o              (rx_valid_o),
      .ch_yumi_i               (rx_yumi_i),
      .credit_local_return_o   (credit_return),
      .credit_local_return_v_o (credit_return_v),
      .credit_remote_pending_o (credit_pending),
      .credit_sent_i           (credit_sent)
   );

endmodule

// ==== src/channel_tunnel_in.sv ====
/*
 * inbound side of a tunnel endpoint
 * steers data flits into per-channel FIFOs and tracks credits owed back
 */

`timescale 1ns/1ps

module channel_tunnel_in import tunnel_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_i,
   input  flit_t             link_flit_i,
   input  logic              link_valid_i,
   output logic              link_yumi_o,
   output ch_data_t          ch_data_o,
   output logic [NUM_CH-1:0] ch_valid_o,
   input  logic [NUM_CH-1:0] ch_yumi_i,
   output credit_vec_t       credit_local_return_o,
   output logic              credit_local_return_v_o,
   output credit_vec_t       credit_remote_pending_o,
   input  logic              credit_sent_i
);

   flit_kind_e        kind;
   logic [NUM_CH-1:0] fifo_wr;
   credit_vec_t       pending_q;

   // receive side never stalls, FIFO space is guaranteed by credits
   assign link_yumi_o = link_valid_i;

   assign kind = (link_flit_i.tag == TAG_W'(NUM_CH)) ? KIND_CREDIT : KIND_DATA;

   // credits the remote side hands back to our sender
   assign credit_local_return_v_o = link_valid_i && (kind == KIND_CREDIT);
   assign credit_local_return_o   = credit_vec_t'(link_flit_i.payload[NUM_CH*CREDIT_W-1:0]);

   for (genvar i = 0; i < NUM_CH; i++) begin : g_chan
      assign fifo_wr[i] = link_valid_i && (kind == KIND_DATA) &&
                          (link_flit_i.tag == TAG_W'(i));

      channel_fifo u_channel_fifo (
         .clk_i   (clk_i),
         .rst_i   (rst_i),
         .data_i  (link_flit_i.payload),
         .valid_i (fifo_wr[i]),
         .data_o  (ch_data_o[i]),
         .valid_o (ch_valid_o[i]),
         .yumi_i  (ch_yumi_i[i])
      );

      // drained words owed to the remote sender
      // a drain in the send cycle is kept as the new count
      always_ff @(posedge clk_i) begin
         if (rst_i) begin
            pending_q[i] <= '0;
         end else if (credit_sent_i) begin
            pending_q[i] <= CREDIT_W'(ch_yumi_i[i]);
         end else begin
            pending_q[i] <= pending_q[i] + CREDIT_W'(ch_yumi_i[i]);
         end
      end
   end

   assign credit_remote_pending_o = pending_q;

endmodule

// ==== src/channel_tunnel_out.sv ====
/*
 * outbound side of a tunnel endpoint
 * gates channels on credit, builds credit flits and arbitrates onto the link
 */

`timescale 1ns/1ps

module channel_tunnel_out import tunnel_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_i,
   input  ch_data_t    ch_data_i,
   input  logic [NUM_CH-1:0] ch_valid_i,
   output logic [NUM_CH-1:0] ch_yumi_o,
   output flit_t       link_flit_o,
   output logic        link_valid_o,
   input  logic        link_yumi_i,
   input  credit_vec_t credit_local_return_i,
   input  logic        credit_local_return_v_i,
   input  credit_vec_t credit_remote_pending_i,
   output logic        credit_sent_o
);

   credit_vec_t         local_credits;
   logic [NUM_CH-1:0]   credit_avail;
   logic [NUM_CH-1:0]   pending_ready;
   logic                credit_req;
   logic [DATA_W-1:0]   credit_word;
   logic [NUM_CH:0]     arb_yumi;

   for (genvar i = 0; i < NUM_CH; i++) begin : g_credit
      credit_counter u_credit_counter (
         .clk_i   (clk_i),
         .rst_i   (rst_i),
         .up_i    (credit_local_return_v_i ? credit_local_return_i[i] : '0),
         .down_i  (ch_yumi_o[i]),
         .count_o (local_credits[i])
      );

      assign credit_avail[i]  = |local_credits[i];
      // threshold reached when any bit at or above LG_DECIMATION is set
      assign pending_ready[i] = |credit_remote_pending_i[i][CREDIT_W-1:LG_DECIMATION];
   end

   assign credit_req  = |pending_ready;
   // the whole pending vector rides in the low payload bits
   assign credit_word = DATA_W'(credit_remote_pending_i);

   rr_arbiter u_rr_arbiter (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .data_i  ({credit_word, ch_data_i}),
      .valid_i ({credit_req, ch_valid_i & credit_avail}),
      .yumi_o  (arb_yumi),
      .flit_o  (link_flit_o),
      .valid_o (link_valid_o),
      .yumi_i  (link_yumi_i)
   );

   assign ch_yumi_o     = arb_yumi[NUM_CH-1:0];
   assign credit_sent_o = arb_yumi[NUM_CH];

endmodule

// ==== src/credit_counter.sv ====
/*
 * credit counter for one channel
 * adds a variable return step and subtracts one per word sent
 */

`timescale 1ns/1ps

module credit_counter import tunnel_pkg::*; (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic [CREDIT_W-1:0] up_i,
   input  logic                down_i,
   output logic [CREDIT_W-1:0] count_o
);

   logic [CREDIT_W-1:0] count_q;

   // credits in flight are bounded, so the count stays in 0..REMOTE_CREDITS
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         count_q <= CREDIT_W'(REMOTE_CREDITS);
      end else begin
         count_q <= count_q + up_i - CREDIT_W'(down_i);
      end
   end

   assign count_o = count_q;

endmodule

// ==== src/rr_arbiter.sv ====
/*
 * round-robin n-to-1 selector
 * tags the chosen word with the index of the winning requester
 */

`timescale 1ns/1ps

module rr_arbiter import tunnel_pkg::*; (
   input  logic                           clk_i,
   input  logic                           rst_i,
   // data channels in the low entries, credit word on top
   input  logic [NUM_CH:0][DATA_W-1:0]    data_i,
   input  logic [NUM_CH:0]                valid_i,
   output logic [NUM_CH:0]                yumi_o,
   output flit_t                          flit_o,
   output logic                           valid_o,
   input  logic                           yumi_i
);

   logic [TAG_W-1:0] ptr_q;
   logic [TAG_W-1:0] win_idx;
   logic             any_valid;

   // first valid requester at or after the pointer wins
   always_comb begin
      int idx;
      any_valid = 1'b0;
      win_idx   = '0;
      for (int k = 0; k <= NUM_CH; k++) begin
         idx = (int'(ptr_q) + k) % (NUM_CH + 1);
         if (!any_valid && valid_i[idx]) begin
            any_valid = 1'b1;
            win_idx   = TAG_W'(idx);
         end
      end
   end

   assign valid_o        = any_valid;
   assign flit_o.tag     = win_idx;
   assign flit_o.payload = data_i[win_idx];

   always_comb begin
      yumi_o = '0;
      if (yumi_i) begin
         yumi_o[win_idx] = 1'b1;
      end
   end

   // next search starts just past the last winner
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ptr_q <= '0;
      end else if (yumi_i) begin
         ptr_q <= (win_idx == TAG_W'(NUM_CH)) ? '0 : win_idx + 1'b1;
      end
   end

endmodule

// ==== src/tunnel_link.sv ====
/*
 * two tunnel endpoints joined back to back
 */

`timescale 1ns/1ps

module tunnel_link import tunnel_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_i,
   input  ch_data_t          a_tx_data_i,
   input  logic [NUM_CH-1:0] a_tx_valid_i,
   output logic [NUM_CH-1:0] a_tx_yumi_o,
   output ch_data_t          a_rx_data_o,
   output logic [NUM_CH-1:0] a_rx_valid_o,
   input  logic [NUM_CH-1:0] a_rx_yumi_i,
   input  ch_data_t          b_tx_data_i,
   input  logic [NUM_CH-1:0] b_tx_valid_i,
   output logic [NUM_CH-1:0] b_tx_yumi_o,
   output ch_data_t          b_rx_data_o,
   output logic [NUM_CH-1:0] b_rx_valid_o,
   input  logic [NUM_CH-1:0] b_rx_yumi_i
);

   // a_to_b carries A's outbound flits, b_to_a the reverse
   flit_t a_to_b_flit;
   logic  a_to_b_valid;
   logic  a_to_b_yumi;
   flit_t b_to_a_flit;
   logic  b_to_a_valid;
   logic  b_to_a_yumi;

   channel_tunnel u_end_a (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .tx_data_i    (a_tx_data_i),
      .tx_valid_i   (a_tx_valid_i),
      .tx_yumi_o    (a_tx_yumi_o),
      .rx_data_o    (a_rx_data_o),
      .rx_valid_o   (a_rx_valid_o),
      .rx_yumi_i    (a_rx_yumi_i),
      .link_flit_o  (a_to_b_flit),
      .link_valid_o (a_to_b_valid),
      .link_yumi_i  (a_to_b_yumi),
      .link_flit_i  (b_to_a_flit),
      .link_valid_i (b_to_a_valid),
      .link_yumi_o  (b_to_a_yumi)
   );

   channel_tunnel u_end_b (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .tx_data_i    (b_tx_data_i),
      .tx_valid_i   (b_tx_valid_i),
      .tx_yumi_o    (b_tx_yumi_o),
      .rx_data_o    (b_rx_data_o),
      .rx_valid_o   (b_rx_valid_o),
      .rx_yumi_i    (b_rx_yumi_i),
      .link_flit_o  (b_to_a_flit),
      .link_valid_o (b_to_a_valid),
      .link_yumi_i  (b_to_a_yumi),
      .link_flit_i  (a_to_b_flit),
      .link_valid_i (a_to_b_valid),
      .link_yumi_o  (a_to_b_yumi)
   );

endmodule

// ==== src/tunnel_pkg.sv ====
/*
 * channel tunnel package
 * sizes, flit layout and flit kinds shared by both endpoints
 */

package tunnel_pkg;

   // number of tunneled data channels
   localparam int NUM_CH = 3;

   // payload width of one flit
   localparam int DATA_W = 16;

   // receive FIFO depth, also the initial credit per channel
   localparam int REMOTE_CREDITS = 8;

   // one credit count, must hold 0 to REMOTE_CREDITS
   localparam int CREDIT_W = 4;

   // tag covers the data channels plus the credit channel
   localparam int TAG_W = $clog2(NUM_CH + 1);

   // credit flit goes out once a pending count reaches 2**LG_DECIMATION
   localparam int LG_DECIMATION = 2;

   // read/write pointer width of a receive FIFO
   localparam int FIFO_PTR_W = $clog2(REMOTE_CREDITS);

   // all credit counts travel in a single flit, so DATA_W must be
   // at least NUM_CH*CREDIT_W (16 >= 12 here)
   typedef logic [NUM_CH-1:0][CREDIT_W-1:0] credit_vec_t;
   typedef logic [NUM_CH-1:0][DATA_W-1:0]   ch_data_t;

   typedef struct packed {
      logic [TAG_W-1:0]  tag;
      logic [DATA_W-1:0] payload;
   } flit_t;

   typedef enum logic {
      KIND_DATA,
      KIND_CREDIT
   } flit_kind_e;

endpackage
